// File: logic/ooo_pkg.sv
`default_nettype none

package ooo_pkg;

	parameter int DATA_W = 16;
	parameter int REG_COUNT = 8;

	typedef logic [DATA_W-1:0] word_t;
	typedef logic [$clog2(REG_COUNT)-1:0] reg_addr_t;
	typedef logic [3:0] tag_t; // Wrapping sequence number
	typedef logic [15:0] instr_t;
	typedef logic [0:0] alu_op_t;

	parameter alu_op_t ALU_ADD = 1'b0;
	parameter alu_op_t ALU_SUB = 1'b1;

	// Major opcodes in instr[15:11]
	parameter logic [4:0] OPC_ADD_IMM = 5'b00000;
	parameter logic [4:0] OPC_ADD_REG = 5'b00001;
	parameter logic [4:0] OPC_SUB_IMM = 5'b00010;
	parameter logic [4:0] OPC_SUB_REG = 5'b00011;

	// A waiting field holds its tag in the low bits
	function automatic logic tag_match(input word_t field, input logic valid, input tag_t tag);
		return valid && (tag_t'(field) == tag);
	endfunction

endpackage

`default_nettype wire

// File: logic/alu_unit.sv
`default_nettype none
`timescale 1ns/1ps

module alu_unit (
	input  logic               clk,
	input  logic               reset,
	input  logic               iss_valid,
	input  ooo_pkg::alu_op_t   iss_op,
	input  ooo_pkg::word_t     iss_a,
	input  ooo_pkg::word_t     iss_b,
	input  ooo_pkg::tag_t      iss_tag,
	input  ooo_pkg::reg_addr_t iss_dest,
	input  ooo_pkg::word_t     iss_pc,
	output logic               bc_valid,
	output ooo_pkg::tag_t      bc_tag,
	output ooo_pkg::word_t     bc_value,
	output ooo_pkg::reg_addr_t bc_dest,
	output ooo_pkg::word_t     bc_pc
);

	always_ff @(posedge clk) begin
		if (reset)
			bc_valid <= 1'b0;
		else
			bc_valid <= iss_valid;
	end

	always_ff @(posedge clk) begin
		bc_value <= (iss_op == ooo_pkg::ALU_SUB) ? iss_a - iss_b : iss_a + iss_b;
		bc_tag <= iss_tag;
		bc_dest <= iss_dest;
		bc_pc <= iss_pc;
	end

endmodule

`default_nettype wire

// File: logic/arch_regfile.sv
`default_nettype none
`timescale 1ns/1ps

module arch_regfile (
	input  logic               clk,
	input  logic               reset,
	input  logic               wr,
	input  ooo_pkg::reg_addr_t wr_addr,
	input  ooo_pkg::word_t     wr_value,
	input  ooo_pkg::reg_addr_t rd_addr,
	output ooo_pkg::word_t     rd_value
);

	ooo_pkg::word_t regs_q [ooo_pkg::REG_COUNT];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < ooo_pkg::REG_COUNT; i++)
				regs_q[i] <= '0;
		end else if (wr) begin
			regs_q[wr_addr] <= wr_value;
		end
	end

	// Commit visible in its own cycle
	assign rd_value = (wr && wr_addr == rd_addr) ? wr_value : regs_q[rd_addr];

endmodule

`default_nettype wire

// File: logic/rename_table.sv
`default_nettype none
`timescale 1ns/1ps

module rename_table (
	input  logic               clk,
	input  logic               reset,
	input  ooo_pkg::reg_addr_t rd_addr_a,
	input  ooo_pkg::reg_addr_t rd_addr_b,
	output logic               rd_ready_a,
	output logic               rd_ready_b,
	output ooo_pkg::word_t     rd_field_a,
	output ooo_pkg::word_t     rd_field_b,
	input  logic               claim,
	input  ooo_pkg::reg_addr_t claim_addr,
	input  ooo_pkg::tag_t      claim_tag,
	input  logic               bc0_valid,
	input  ooo_pkg::tag_t      bc0_tag,
	input  ooo_pkg::word_t     bc0_value,
	input  logic               bc1_valid,
	input  ooo_pkg::tag_t      bc1_tag,
	input  ooo_pkg::word_t     bc1_value
);

	ooo_pkg::word_t                 field_q [ooo_pkg::REG_COUNT]; // Value, or tag when pending
	logic [ooo_pkg::REG_COUNT-1:0] pend_q;
	logic [1:0]                     hit_a, hit_b;

	// Forward a result broadcast this cycle
	assign hit_a[0] = pend_q[rd_addr_a] && ooo_pkg::tag_match(field_q[rd_addr_a], bc0_valid, bc0_tag);
	assign hit_a[1] = pend_q[rd_addr_a] && ooo_pkg::tag_match(field_q[rd_addr_a], bc1_valid, bc1_tag);
	assign hit_b[0] = pend_q[rd_addr_b] && ooo_pkg::tag_match(field_q[rd_addr_b], bc0_valid, bc0_tag);
	assign hit_b[1] = pend_q[rd_addr_b] && ooo_pkg::tag_match(field_q[rd_addr_b], bc1_valid, bc1_tag);

	assign rd_ready_a = !pend_q[rd_addr_a] || (|hit_a);
	assign rd_ready_b = !pend_q[rd_addr_b] || (|hit_b);
	assign rd_field_a = hit_a[0] ? bc0_value : (hit_a[1] ? bc1_value : field_q[rd_addr_a]);
	assign rd_field_b = hit_b[0] ? bc0_value : (hit_b[1] ? bc1_value : field_q[rd_addr_b]);

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < ooo_pkg::REG_COUNT; i++) begin
				field_q[i] <= '0;
				pend_q[i] <= 1'b0;
			end
		end else begin
			for (int i = 0; i < ooo_pkg::REG_COUNT; i++) begin
				if (pend_q[i] && ooo_pkg::tag_match(field_q[i], bc0_valid, bc0_tag)) begin
					field_q[i] <= bc0_value;
					pend_q[i] <= 1'b0;
				end
				if (pend_q[i] && ooo_pkg::tag_match(field_q[i], bc1_valid, bc1_tag)) begin
					field_q[i] <= bc1_value;
					pend_q[i] <= 1'b0;
				end
			end
			// Youngest writer wins over a completing older one
			if (claim) begin
				field_q[claim_addr] <= ooo_pkg::word_t'(claim_tag);
				pend_q[claim_addr] <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/dispatch_unit.sv
`default_nettype none
`timescale 1ns/1ps

module dispatch_unit (
	input  logic               clk,
	input  logic               reset,
	input  logic               dec_valid,
	input  ooo_pkg::alu_op_t   dec_op,
	input  ooo_pkg::reg_addr_t dec_dest,
	input  ooo_pkg::reg_addr_t dec_src_a,
	input  ooo_pkg::reg_addr_t dec_src_b,
	input  logic               dec_use_imm,
	input  ooo_pkg::word_t     dec_imm,
	input  ooo_pkg::word_t     dec_pc,
	output logic               stall,
	input  logic               rs_full_0,
	input  logic               rs_full_1,
	input  logic               rob_full,
	input  logic               bc0_valid,
	input  ooo_pkg::tag_t      bc0_tag,
	input  ooo_pkg::word_t     bc0_value,
	input  logic               bc1_valid,
	input  ooo_pkg::tag_t      bc1_tag,
	input  ooo_pkg::word_t     bc1_value,
	output logic               rs_wr_0,
	output logic               rs_wr_1,
	output ooo_pkg::alu_op_t   op,
	output ooo_pkg::tag_t      tag,
	output ooo_pkg::reg_addr_t dest,
	output ooo_pkg::word_t     pc,
	output logic               a_ready,
	output ooo_pkg::word_t     a_field,
	output logic               b_ready,
	output ooo_pkg::word_t     b_field,
	output logic               rob_alloc,
	output ooo_pkg::tag_t      alloc_tag,
	output ooo_pkg::reg_addr_t alloc_dest
);

	ooo_pkg::tag_t  tag_q;
	logic           to_unit_0;
	logic           go;
	logic           b_ready_rn;
	ooo_pkg::word_t b_field_rn;

	rename_table u_rename (
		.clk(clk), .reset(reset),
		.rd_addr_a(dec_src_a), .rd_addr_b(dec_src_b),
		.rd_ready_a(a_ready), .rd_ready_b(b_ready_rn),
		.rd_field_a(a_field), .rd_field_b(b_field_rn),
		.claim(go), .claim_addr(dec_dest), .claim_tag(tag_q),
		.bc0_valid(bc0_valid), .bc0_tag(bc0_tag), .bc0_value(bc0_value),
		.bc1_valid(bc1_valid), .bc1_tag(bc1_tag), .bc1_value(bc1_value)
	);

	assign to_unit_0 = dec_pc[0]; // Odd PCs to ALU 0
	assign stall = dec_valid && ((to_unit_0 ? rs_full_0 : rs_full_1) || rob_full);
	assign go = dec_valid && !stall;

	assign rs_wr_0 = go && to_unit_0;
	assign rs_wr_1 = go && !to_unit_0;
	assign rob_alloc = go;
	assign alloc_tag = tag_q;
	assign alloc_dest = dec_dest;

	assign op = dec_op;
	assign tag = tag_q;
	assign dest = dec_dest;
	assign pc = dec_pc;
	assign b_ready = dec_use_imm || b_ready_rn;
	assign b_field = dec_use_imm ? dec_imm : b_field_rn;

	always_ff @(posedge clk) begin
		if (reset)
			tag_q <= '0;
		else if (go)
			tag_q <= tag_q + 1'b1;
	end

endmodule

`default_nettype wire

// File: logic/fetch_decode.sv
`default_nettype none
`timescale 1ns/1ps

module fetch_decode (
	input  logic               clk,
	input  logic               reset,
	input  logic               stall,
	output ooo_pkg::word_t     fetch_addr,
	input  ooo_pkg::instr_t    instr,
	output logic               dec_valid,
	output ooo_pkg::alu_op_t   dec_op,
	output ooo_pkg::reg_addr_t dec_dest,
	output ooo_pkg::reg_addr_t dec_src_a,
	output ooo_pkg::reg_addr_t dec_src_b,
	output logic               dec_use_imm,
	output ooo_pkg::word_t     dec_imm,
	output ooo_pkg::word_t     dec_pc
);

	ooo_pkg::word_t  pc_q;     // Next fetch address
	ooo_pkg::word_t  dec_pc_q;
	logic            in_valid_q; // Memory has answered at least once
	ooo_pkg::instr_t hold_q;
	logic            hold_valid_q;
	ooo_pkg::instr_t inst;
	logic [4:0]      opcode;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc_q <= '0;
			dec_pc_q <= '0;
			in_valid_q <= 1'b0;
			hold_valid_q <= 1'b0;
		end else if (stall) begin
			hold_valid_q <= 1'b1;
		end else begin
			pc_q <= pc_q + 1'b1;
			dec_pc_q <= pc_q;
			in_valid_q <= 1'b1;
			hold_valid_q <= 1'b0;
		end
	end

	// Memory moves on during a stall, so keep the word being decoded
	always_ff @(posedge clk) begin
		if (stall && !hold_valid_q)
			hold_q <= instr;
	end

	assign inst = hold_valid_q ? hold_q : instr;
	assign opcode = inst[15:11];

	assign fetch_addr = pc_q;
	assign dec_pc = dec_pc_q;
	assign dec_dest = inst[10:8];
	assign dec_src_a = inst[7:5];
	assign dec_src_b = inst[2:0];
	assign dec_imm = {{(ooo_pkg::DATA_W - 5){inst[4]}}, inst[4:0]};

	always_comb begin
		dec_valid = in_valid_q;
		dec_op = ooo_pkg::ALU_ADD;
		dec_use_imm = 1'b0;
		case (opcode)
			ooo_pkg::OPC_ADD_IMM: dec_use_imm = 1'b1;
			ooo_pkg::OPC_ADD_REG: dec_use_imm = 1'b0;
			ooo_pkg::OPC_SUB_IMM: begin
				dec_op = ooo_pkg::ALU_SUB;
				dec_use_imm = 1'b1;
			end
			ooo_pkg::OPC_SUB_REG: dec_op = ooo_pkg::ALU_SUB;
			default: dec_valid = 1'b0; // Loads, stores, junk
		endcase
	end

endmodule

`default_nettype wire

// File: logic/reservation_station.sv
`default_nettype none
`timescale 1ns/1ps

module reservation_station #(
	parameter int RS_DEPTH = 4
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               wr,
	input  ooo_pkg::alu_op_t   op,
	input  ooo_pkg::tag_t      tag,
	input  ooo_pkg::reg_addr_t dest,
	input  ooo_pkg::word_t     pc,
	input  logic               a_ready,
	input  ooo_pkg::word_t     a_field,
	input  logic               b_ready,
	input  ooo_pkg::word_t     b_field,
	output logic               full,
	input  logic               bc0_valid,
	input  ooo_pkg::tag_t      bc0_tag,
	input  ooo_pkg::word_t     bc0_value,
	input  logic               bc1_valid,
	input  ooo_pkg::tag_t      bc1_tag,
	input  ooo_pkg::word_t     bc1_value,
	output logic               iss_valid,
	output ooo_pkg::alu_op_t   iss_op,
	output ooo_pkg::word_t     iss_a,
	output ooo_pkg::word_t     iss_b,
	output ooo_pkg::tag_t      iss_tag,
	output ooo_pkg::reg_addr_t iss_dest,
	output ooo_pkg::word_t     iss_pc
);

	localparam int IDX_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;

	logic [RS_DEPTH-1:0] busy_q, a_rdy_q, b_rdy_q;
	ooo_pkg::alu_op_t    op_q [RS_DEPTH];
	ooo_pkg::tag_t       tag_q [RS_DEPTH];
	ooo_pkg::reg_addr_t  dest_q [RS_DEPTH];
	ooo_pkg::word_t      pc_q [RS_DEPTH];
	ooo_pkg::word_t      a_q [RS_DEPTH];
	ooo_pkg::word_t      b_q [RS_DEPTH];
	logic [IDX_W-1:0]    free_idx, iss_idx;

	//////////////////////////////////////////////////
	// Slot pick with the lowest index first

	always_comb begin
		free_idx = '0;
		iss_idx = '0;
		iss_valid = 1'b0;
		for (int i = RS_DEPTH - 1; i >= 0; i--) begin
			if (!busy_q[i])
				free_idx = IDX_W'(i);
			if (busy_q[i] && a_rdy_q[i] && b_rdy_q[i]) begin
				iss_idx = IDX_W'(i);
				iss_valid = 1'b1;
			end
		end
	end

	assign full = &busy_q;
	assign iss_op = op_q[iss_idx];
	assign iss_a = a_q[iss_idx];
	assign iss_b = b_q[iss_idx];
	assign iss_tag = tag_q[iss_idx];
	assign iss_dest = dest_q[iss_idx];
	assign iss_pc = pc_q[iss_idx];

	always_ff @(posedge clk) begin
		if (reset) begin
			busy_q <= '0;
		end else begin
			if (iss_valid)
				busy_q[iss_idx] <= 1'b0;
			if (wr)
				busy_q[free_idx] <= 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Operand wake-up and entry write

	always_ff @(posedge clk) begin
		for (int i = 0; i < RS_DEPTH; i++) begin
			if (!a_rdy_q[i] && ooo_pkg::tag_match(a_q[i], bc0_valid, bc0_tag)) begin
				a_q[i] <= bc0_value;
				a_rdy_q[i] <= 1'b1;
			end
			if (!a_rdy_q[i] && ooo_pkg::tag_match(a_q[i], bc1_valid, bc1_tag)) begin
				a_q[i] <= bc1_value;
				a_rdy_q[i] <= 1'b1;
			end
			if (!b_rdy_q[i] && ooo_pkg::tag_match(b_q[i], bc0_valid, bc0_tag)) begin
				b_q[i] <= bc0_value;
				b_rdy_q[i] <= 1'b1;
			end
			if (!b_rdy_q[i] && ooo_pkg::tag_match(b_q[i], bc1_valid, bc1_tag)) begin
				b_q[i] <= bc1_value;
				b_rdy_q[i] <= 1'b1;
			end
		end
		if (wr) begin
			op_q[free_idx] <= op;
			tag_q[free_idx] <= tag;
			dest_q[free_idx] <= dest;
			pc_q[free_idx] <= pc;
			a_q[free_idx] <= a_field;
			a_rdy_q[free_idx] <= a_ready;
			b_q[free_idx] <= b_field;
			b_rdy_q[free_idx] <= b_ready;
		end
	end

endmodule

`default_nettype wire

// File: logic/reorder_buffer.sv
`default_nettype none
`timescale 1ns/1ps

module reorder_buffer #(
	parameter int ROB_DEPTH = 8
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               alloc,
	input  ooo_pkg::tag_t      alloc_tag,
	output logic               full,
	input  logic               bc0_valid,
	input  ooo_pkg::tag_t      bc0_tag,
	input  ooo_pkg::word_t     bc0_value,
	input  ooo_pkg::reg_addr_t bc0_dest,
	input  ooo_pkg::word_t     bc0_pc,
	input  logic               bc1_valid,
	input  ooo_pkg::tag_t      bc1_tag,
	input  ooo_pkg::word_t     bc1_value,
	input  ooo_pkg::reg_addr_t bc1_dest,
	input  ooo_pkg::word_t     bc1_pc,
	output logic               commit_valid,
	output ooo_pkg::reg_addr_t commit_reg,
	output ooo_pkg::word_t     commit_value,
	output ooo_pkg::word_t     commit_pc
);

	localparam int SLOT_W = $clog2(ROB_DEPTH);

	ooo_pkg::tag_t        head_q;  // Oldest tag in flight
	logic [SLOT_W:0]      count_q;
	logic [ROB_DEPTH-1:0] done_q;
	ooo_pkg::word_t       value_q [ROB_DEPTH];
	ooo_pkg::reg_addr_t   reg_q [ROB_DEPTH];
	ooo_pkg::word_t       pc_q [ROB_DEPTH];
	logic [SLOT_W-1:0]    head_slot, alloc_slot, slot0, slot1;

	// Slot is the tag's low bits
	assign head_slot = head_q[SLOT_W-1:0];
	assign alloc_slot = alloc_tag[SLOT_W-1:0];
	assign slot0 = bc0_tag[SLOT_W-1:0];
	assign slot1 = bc1_tag[SLOT_W-1:0];

	assign full = (count_q == (SLOT_W + 1)'(ROB_DEPTH));
	assign commit_valid = (count_q != '0) && done_q[head_slot];
	assign commit_reg = reg_q[head_slot];
	assign commit_value = value_q[head_slot];
	assign commit_pc = pc_q[head_slot];

	always_ff @(posedge clk) begin
		if (reset) begin
			head_q <= '0;
			count_q <= '0;
			done_q <= '0;
		end else begin
			if (commit_valid)
				head_q <= head_q + 1'b1;
			count_q <= count_q + (SLOT_W + 1)'(alloc) - (SLOT_W + 1)'(commit_valid);
			if (alloc)
				done_q[alloc_slot] <= 1'b0;
			if (bc0_valid)
				done_q[slot0] <= 1'b1;
			if (bc1_valid)
				done_q[slot1] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (bc0_valid) begin
			value_q[slot0] <= bc0_value;
			reg_q[slot0] <= bc0_dest;
			pc_q[slot0] <= bc0_pc;
		end
		if (bc1_valid) begin
			value_q[slot1] <= bc1_value;
			reg_q[slot1] <= bc1_dest;
			pc_q[slot1] <= bc1_pc;
		end
	end

endmodule

`default_nettype wire

// File: logic/ooo_core.sv
`default_nettype none
`timescale 1ns/1ps

module ooo_core #(
	parameter int RS_DEPTH = 4,
	parameter int ROB_DEPTH = 8
) (
	input  logic               clk,
	input  logic               reset,
	output ooo_pkg::word_t     fetch_addr,
	input  ooo_pkg::instr_t    instr,
	output logic               commit_valid,
	output ooo_pkg::reg_addr_t commit_reg,
	output ooo_pkg::word_t     commit_value,
	output ooo_pkg::word_t     commit_pc,
	input  ooo_pkg::reg_addr_t dbg_addr,
	output ooo_pkg::word_t     dbg_value
);

	logic               stall;
	logic               dec_valid;
	logic               dec_use_imm;
	ooo_pkg::alu_op_t   dec_op;
	ooo_pkg::reg_addr_t dec_dest, dec_src_a, dec_src_b;
	ooo_pkg::word_t     dec_imm, dec_pc;

	logic [1:0]         rs_wr, rs_full;
	logic               rob_full, rob_alloc;
	ooo_pkg::tag_t      alloc_tag;

	// Station entry shared by both units
	ooo_pkg::alu_op_t   e_op;
	ooo_pkg::tag_t      e_tag;
	ooo_pkg::reg_addr_t e_dest;
	ooo_pkg::word_t     e_pc, e_a_field, e_b_field;
	logic               e_a_ready, e_b_ready;

	logic [1:0]         iss_valid, bc_valid;
	ooo_pkg::alu_op_t   iss_op [2];
	ooo_pkg::word_t     iss_a [2], iss_b [2], iss_pc [2];
	ooo_pkg::tag_t      iss_tag [2], bc_tag [2];
	ooo_pkg::reg_addr_t iss_dest [2], bc_dest [2];
	ooo_pkg::word_t     bc_value [2], bc_pc [2];

	//////////////////////////////////////////////////
	// Front end

	fetch_decode u_fetch (
		.clk(clk), .reset(reset), .stall(stall),
		.fetch_addr(fetch_addr), .instr(instr),
		.dec_valid(dec_valid), .dec_op(dec_op), .dec_dest(dec_dest),
		.dec_src_a(dec_src_a), .dec_src_b(dec_src_b),
		.dec_use_imm(dec_use_imm), .dec_imm(dec_imm), .dec_pc(dec_pc)
	);

	dispatch_unit u_dispatch (
		.clk(clk), .reset(reset),
		.dec_valid(dec_valid), .dec_op(dec_op), .dec_dest(dec_dest),
		.dec_src_a(dec_src_a), .dec_src_b(dec_src_b),
		.dec_use_imm(dec_use_imm), .dec_imm(dec_imm), .dec_pc(dec_pc),
		.stall(stall), .rs_full_0(rs_full[0]), .rs_full_1(rs_full[1]), .rob_full(rob_full),
		.bc0_valid(bc_valid[0]), .bc0_tag(bc_tag[0]), .bc0_value(bc_value[0]),
		.bc1_valid(bc_valid[1]), .bc1_tag(bc_tag[1]), .bc1_value(bc_value[1]),
		.rs_wr_0(rs_wr[0]), .rs_wr_1(rs_wr[1]),
		.op(e_op), .tag(e_tag), .dest(e_dest), .pc(e_pc),
		.a_ready(e_a_ready), .a_field(e_a_field), .b_ready(e_b_ready), .b_field(e_b_field),
		.rob_alloc(rob_alloc), .alloc_tag(alloc_tag), .alloc_dest()
	);

	//////////////////////////////////////////////////
	// Execution with one station per ALU

	for (genvar u = 0; u < 2; u++) begin : g_unit
		reservation_station #(.RS_DEPTH(RS_DEPTH)) u_rs (
			.clk(clk), .reset(reset), .wr(rs_wr[u]),
			.op(e_op), .tag(e_tag), .dest(e_dest), .pc(e_pc),
			.a_ready(e_a_ready), .a_field(e_a_field), .b_ready(e_b_ready), .b_field(e_b_field),
			.full(rs_full[u]),
			.bc0_valid(bc_valid[0]), .bc0_tag(bc_tag[0]), .bc0_value(bc_value[0]),
			.bc1_valid(bc_valid[1]), .bc1_tag(bc_tag[1]), .bc1_value(bc_value[1]),
			.iss_valid(iss_valid[u]), .iss_op(iss_op[u]), .iss_a(iss_a[u]), .iss_b(iss_b[u]),
			.iss_tag(iss_tag[u]), .iss_dest(iss_dest[u]), .iss_pc(iss_pc[u])
		);

		alu_unit u_alu (
			.clk(clk), .reset(reset),
			.iss_valid(iss_valid[u]), .iss_op(iss_op[u]), .iss_a(iss_a[u]), .iss_b(iss_b[u]),
			.iss_tag(iss_tag[u]), .iss_dest(iss_dest[u]), .iss_pc(iss_pc[u]),
			.bc_valid(bc_valid[u]), .bc_tag(bc_tag[u]), .bc_value(bc_value[u]),
			.bc_dest(bc_dest[u]), .bc_pc(bc_pc[u])
		);
	end

	//////////////////////////////////////////////////
	// Retire

	reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) u_rob (
		.clk(clk), .reset(reset),
		.alloc(rob_alloc), .alloc_tag(alloc_tag), .full(rob_full),
		.bc0_valid(bc_valid[0]), .bc0_tag(bc_tag[0]), .bc0_value(bc_value[0]),
		.bc0_dest(bc_dest[0]), .bc0_pc(bc_pc[0]),
		.bc1_valid(bc_valid[1]), .bc1_tag(bc_tag[1]), .bc1_value(bc_value[1]),
		.bc1_dest(bc_dest[1]), .bc1_pc(bc_pc[1]),
		.commit_valid(commit_valid), .commit_reg(commit_reg),
		.commit_value(commit_value), .commit_pc(commit_pc)
	);

	arch_regfile u_regs (
		.clk(clk), .reset(reset),
		.wr(commit_valid), .wr_addr(commit_reg), .wr_value(commit_value),
		.rd_addr(dbg_addr), .rd_value(dbg_value)
	);

endmodule

`default_nettype wire

// File: dv/ooo_core_chk.sv
`default_nettype none
`timescale 1ns/1ps

module ooo_core_chk (
	input wire logic           clk,
	input wire logic           reset,
	input wire logic           commit_valid,
	input wire ooo_pkg::word_t commit_pc
);

	logic           reset_q;
	logic           seen_q; // A commit since reset
	ooo_pkg::word_t last_pc_q;
	int             fail_count = 0;

	always_ff @(posedge clk) begin
		reset_q <= reset;
		if (reset) begin
			seen_q <= 1'b0;
		end else if (commit_valid) begin
			seen_q <= 1'b1;
			last_pc_q <= commit_pc;
		end
	end

	no_commit_in_reset: assert property (@(posedge clk) reset && reset_q |-> !commit_valid)
		else begin
			fail_count++;
			$error("commit_valid high while reset is held");
		end

	// Program order
	pc_increases: assert property (@(posedge clk) disable iff (reset)
		commit_valid && seen_q |-> commit_pc > last_pc_q)
		else begin
			fail_count++;
			$error("commit_pc did not increase over the previous commit");
		end

endmodule

`default_nettype wire

// File: dv/ooo_core_tb.sv
`default_nettype none
`timescale 1ns/1ps

module ooo_core_tb;

	localparam int NUM_TESTS = 6;
	localparam int TIMEOUT = 400 * NUM_TESTS;

	logic               clk = 1'b0;
	logic               reset = 1'b1;
	ooo_pkg::instr_t    instr;
	ooo_pkg::reg_addr_t dbg_addr = '0;
	ooo_pkg::word_t     fetch_addr, commit_value, commit_pc, dbg_value;
	ooo_pkg::reg_addr_t commit_reg;
	logic               commit_valid;

	ooo_pkg::instr_t rom [64];
	int              prog_len = 0;
	ooo_pkg::word_t  next_addr = '0;
	ooo_pkg::word_t  model_regs [ooo_pkg::REG_COUNT];
	ooo_pkg::word_t  exp_pc_q [$], exp_val_q [$];
	int              exp_reg_q [$];
	int              errors = 0;
	int              checks = 0;
	int              cycles = 0;

	ooo_core DUT (
		.clk(clk), .reset(reset), .fetch_addr(fetch_addr), .instr(instr),
		.commit_valid(commit_valid), .commit_reg(commit_reg),
		.commit_value(commit_value), .commit_pc(commit_pc),
		.dbg_addr(dbg_addr), .dbg_value(dbg_value)
	);

	bind ooo_core ooo_core_chk u_chk (
		.clk(clk), .reset(reset), .commit_valid(commit_valid), .commit_pc(commit_pc)
	);

	always #10 clk = ~clk;

	//////////////////////////////////////////////////
	// Instruction memory with one edge of read latency

	function automatic ooo_pkg::instr_t rom_word(input ooo_pkg::word_t a);
		if (a < prog_len)
			return rom[a];
		return {5'b11111, a[10:0]}; // Not an instruction
	endfunction

	initial instr = rom_word('0);

	always @(negedge clk) next_addr = fetch_addr;

	always @(posedge clk) begin
		#1;
		instr = rom_word(next_addr);
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT) begin
			errors++;
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT);
			$display("%0d errors in %0d checks", errors, checks);
			$display("tests failed");
			$finish;
		end
	end

	// Commit monitor
	always @(negedge clk) begin
		if (!reset && commit_valid) begin
			checks++;
			assert (exp_pc_q.size() != 0) else begin
				errors++;
				$display("Unexpected commit of pc %h after the program finished", commit_pc);
			end
			if (exp_pc_q.size() != 0) begin
				assert (commit_pc == exp_pc_q[0]) else begin
					errors++;
					$display("Mismatch commit_pc: got %h, expected %h", commit_pc, exp_pc_q[0]);
				end
				assert (int'(commit_reg) == exp_reg_q[0]) else begin
					errors++;
					$display("Mismatch commit_reg: got %h, expected %h", commit_reg,
						exp_reg_q[0]);
				end
				assert (commit_value == exp_val_q[0]) else begin
					errors++;
					$display("Mismatch commit_value: got %h, expected %h (pc %h)",
						commit_value, exp_val_q[0], commit_pc);
				end
				void'(exp_pc_q.pop_front());
				void'(exp_reg_q.pop_front());
				void'(exp_val_q.pop_front());
			end
		end
	end

	//////////////////////////////////////////////////
	// Program build and in-order reference model

	task automatic add_instr(input logic [4:0] opc, input int d, input int a,
			input logic [4:0] low);
		ooo_pkg::word_t av;
		ooo_pkg::word_t bv;
		ooo_pkg::word_t res;
		logic           known;
		rom[prog_len] = {opc, 3'(d), 3'(a), low};
		av = model_regs[a];
		bv = {{11{low[4]}}, low}; // Sign-extended immediate
		known = 1'b1;
		case (opc)
			ooo_pkg::OPC_ADD_IMM: res = av + bv;
			ooo_pkg::OPC_SUB_IMM: res = av - bv;
			ooo_pkg::OPC_ADD_REG: res = av + model_regs[low[2:0]];
			ooo_pkg::OPC_SUB_REG: res = av - model_regs[low[2:0]];
			default: known = 1'b0;
		endcase
		if (known) begin
			exp_pc_q.push_back(ooo_pkg::word_t'(prog_len));
			exp_reg_q.push_back(d);
			exp_val_q.push_back(res);
			model_regs[d] = res;
		end
		prog_len++;
	endtask

	task automatic add_reg_op(input logic [4:0] opc, input int d, input int a, input int b);
		add_instr(opc, d, a, {2'b00, 3'(b)});
	endtask

	function automatic logic [4:0] rand_imm();
		return 5'($urandom);
	endfunction

	// Reset is held while the new program is loaded
	task automatic start_test();
		@(posedge clk);
		#1 reset = 1'b1;
		prog_len = 0;
		for (int r = 0; r < ooo_pkg::REG_COUNT; r++)
			model_regs[r] = '0;
	endtask

	task automatic release_reset();
		repeat (5) @(posedge clk);
		#1 reset = 1'b0;
	endtask

	task automatic drain_and_check();
		while (exp_pc_q.size() != 0)
			@(posedge clk);
		repeat (12) @(posedge clk); // Window for stray commits
		for (int r = 0; r < ooo_pkg::REG_COUNT; r++) begin
			@(posedge clk);
			#1 dbg_addr = 3'(r);
			@(negedge clk);
			checks++;
			assert (dbg_value == model_regs[r]) else begin
				errors++;
				$display("Mismatch dbg_value r%0d: got %h, expected %h", r, dbg_value,
					model_regs[r]);
			end
		end
	endtask

	//////////////////////////////////////////////////
	// Directed tests

	task automatic reset_state();
		start_test();
		release_reset();
		repeat (20) @(posedge clk);
		drain_and_check();
	endtask

	task automatic independent_imm();
		start_test();
		for (int i = 0; i < 8; i++)
			add_instr(i[0] ? ooo_pkg::OPC_SUB_IMM : ooo_pkg::OPC_ADD_IMM, i, i, rand_imm());
		release_reset();
		drain_and_check();
	endtask

	task automatic dependent_chain();
		int prev;
		int prev2;
		int d;
		start_test();
		add_instr(ooo_pkg::OPC_ADD_IMM, 1, 0, rand_imm());
		add_instr(ooo_pkg::OPC_SUB_IMM, 2, 1, rand_imm());
		prev2 = 1;
		prev = 2;
		for (int i = 0; i < 10; i++) begin
			d = ((i + 2) % 7) + 1;
			add_reg_op(i[0] ? ooo_pkg::OPC_SUB_REG : ooo_pkg::OPC_ADD_REG, d, prev, prev2);
			prev2 = prev;
			prev = d;
		end
		release_reset();
		drain_and_check();
	endtask

	task automatic repeated_dest();
		start_test();
		add_instr(ooo_pkg::OPC_ADD_IMM, 5, 5, rand_imm());
		add_instr(ooo_pkg::OPC_SUB_IMM, 5, 5, rand_imm());
		add_reg_op(ooo_pkg::OPC_ADD_REG, 3, 5, 5);
		add_reg_op(ooo_pkg::OPC_ADD_REG, 5, 5, 5);
		add_instr(ooo_pkg::OPC_ADD_IMM, 5, 0, rand_imm()); // Breaks the chain
		add_instr(ooo_pkg::OPC_SUB_IMM, 5, 5, rand_imm());
		add_reg_op(ooo_pkg::OPC_SUB_REG, 5, 5, 3);
		release_reset();
		drain_and_check();
	endtask

	task automatic fill_queues();
		start_test();
		for (int i = 0; i < 16; i++)
			add_instr(ooo_pkg::OPC_ADD_IMM, 1, 1, rand_imm());
		for (int i = 0; i < 12; i++)
			add_instr(i[0] ? ooo_pkg::OPC_SUB_IMM : ooo_pkg::OPC_ADD_IMM, 2 + (i % 6), 0,
				rand_imm());
		release_reset();
		drain_and_check();
	endtask

	task automatic unknown_opcodes();
		start_test();
		add_instr(ooo_pkg::OPC_ADD_IMM, 1, 0, rand_imm());
		add_instr(5'b10000, 2, 1, rand_imm()); // Load
		add_reg_op(ooo_pkg::OPC_ADD_REG, 2, 1, 1);
		add_instr(5'b10001, 3, 2, rand_imm()); // Store
		add_instr(5'b11111, 4, 2, rand_imm());
		add_instr(ooo_pkg::OPC_SUB_IMM, 3, 2, rand_imm());
		add_instr(5'b00111, 5, 3, rand_imm());
		add_reg_op(ooo_pkg::OPC_SUB_REG, 6, 3, 1);
		release_reset();
		drain_and_check();
	endtask

	initial begin
		void'($urandom(32'hdd9df8b7));
		reset_state();
		independent_imm();
		dependent_chain();
		repeated_dest();
		fill_queues();
		unknown_opcodes();
		errors += DUT.u_chk.fail_count; // Bound assertion failures
		$display("%0d errors in %0d checks", errors, checks);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
logic/ooo_pkg.sv
logic/alu_unit.sv
logic/arch_regfile.sv
logic/rename_table.sv
logic/dispatch_unit.sv
logic/fetch_decode.sv
logic/reservation_station.sv
logic/reorder_buffer.sv
logic/ooo_core.sv
dv/ooo_core_chk.sv
dv/ooo_core_tb.sv
